//--- hisBuilder_defines.svh
`ifndef HIS_BUILDER_DEFINES_SVH
`define HIS_BUILDER_DEFINES_SVH

// histogram geometry

// coarse bin index width
`define HIS_NB 4

// fine index width, covers the coarse range at higher resolution
`define HIS_NP 8

// per-bin hit counter width
`define HIS_CNT_W 8

// acquisition structure of one frame

// pixels per frame
`define HIS_PIXEL_NUM 4

// samples per pixel in one acquisition
`define HIS_DATA_NUM 8

// acquisitions before the frame closes
`define HIS_ACQ_NUM 2

// derived sizes

// one counter per coarse bin
`define HIS_BIN_NUM (1 << `HIS_NB)

// half the readout window, in fine units
`define HIS_HALF_WIN (1 << (`HIS_NB - 1))

// pixel number width, must hold HIS_PIXEL_NUM - 1
`define HIS_PIX_W 2

`endif

//--- hisBuilderPkg.sv
`include "hisBuilder_defines.svh"

package hisBuilderPkg;

    // coarse bin of one sample
    typedef logic [`HIS_NB-1:0] binIdx_t;

    // fine position, used for window bounds
    typedef logic [`HIS_NP-1:0] fineIdx_t;

    // hit count of one bin
    typedef logic [`HIS_CNT_W-1:0] binCount_t;

    // pixel number within a frame
    typedef logic [`HIS_PIX_W-1:0] pixelIdx_t;

endpackage

//--- hisFrameSequencer.sv
`include "hisBuilder_defines.svh"

module hisFrameSequencer (
    input  logic                    clk,
    input  logic                    combin_res,
    input  logic                    wrEn,
    output hisBuilderPkg::pixelIdx_t pixelIdx,
    output logic                    frameEnd,
    output logic                    frameParity
);
    import hisBuilderPkg::*;

    // counter widths, +1 keeps a width of at least 1
    localparam int SAMP_W = $clog2(`HIS_DATA_NUM + 1);
    localparam int ACQ_W  = $clog2(`HIS_ACQ_NUM + 1);

    logic [SAMP_W-1:0] sampleCnt;
    pixelIdx_t         pixelCnt;
    logic [ACQ_W-1:0]  acqCnt;

    logic sampleLast;
    logic pixelLast;
    logic acqLast;
    logic lastSample;

    // wrap points of the nested counters
    assign sampleLast = (sampleCnt == SAMP_W'(`HIS_DATA_NUM - 1));
    assign pixelLast  = (pixelCnt == pixelIdx_t'(`HIS_PIXEL_NUM - 1));
    assign acqLast    = (acqCnt == ACQ_W'(`HIS_ACQ_NUM - 1));
    assign lastSample = sampleLast && pixelLast && acqLast;

    // current pixel goes straight to the bin memory
    assign pixelIdx = pixelCnt;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt   <= '0;
            pixelCnt    <= '0;
            acqCnt      <= '0;
            frameEnd    <= 1'b0;
            frameParity <= 1'b0;
        end else begin
            // one pulse per frame, the cycle after the final sample
            frameEnd <= wrEn && lastSample;
            if (wrEn && lastSample) begin
                frameParity <= ~frameParity;
            end
            // idle cycles hold every counter
            if (wrEn) begin
                if (sampleLast) begin
                    sampleCnt <= '0;
                    if (pixelLast) begin
                        pixelCnt <= '0;
                        // after the last acquisition, back to the first
                        if (acqLast) begin
                            acqCnt <= '0;
                        end else begin
                            acqCnt <= acqCnt + 1'b1;
                        end
                    end else begin
                        pixelCnt <= pixelCnt + 1'b1;
                    end
                end else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
            end
        end
    end

    // frame end is a single-cycle pulse, frames hold many samples
    assert property (@(posedge clk) disable iff (!combin_res)
        frameEnd |=> !frameEnd);

endmodule

//--- hisBinMemory.sv
`include "hisBuilder_defines.svh"

module hisBinMemory (
    input  logic                     clk,
    input  logic                     combin_res,
    input  logic                     wrEn,
    input  logic                     frameEnd,
    input  hisBuilderPkg::binIdx_t   addr,
    input  hisBuilderPkg::pixelIdx_t pixelIdx,
    output logic                     cntValid,
    output hisBuilderPkg::binCount_t binCount,
    output hisBuilderPkg::pixelIdx_t cntPixel,
    output hisBuilderPkg::binIdx_t   cntBin
);
    import hisBuilderPkg::*;

    // one entry per pixel and bin
    localparam int ENTRIES = `HIS_PIXEL_NUM * `HIS_BIN_NUM;
    localparam int IDX_W   = `HIS_PIX_W + `HIS_NB;

    binCount_t        countMem [ENTRIES];
    logic [ENTRIES-1:0] validFlag;

    logic [IDX_W-1:0] wrIdx;
    logic             firstHit;
    binCount_t        nextCount;

    // pixel selects the block, bin the entry inside it
    assign wrIdx = {pixelIdx, addr};

    // stale entries from the last frame count as empty
    // a sample in the frame end cycle already belongs to the new frame
    assign firstHit  = !validFlag[wrIdx] || frameEnd;
    assign nextCount = firstHit ? binCount_t'(1) : countMem[wrIdx] + 1'b1;

    // valid flags are cleared as a whole at frame end
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            validFlag <= '0;
        end else begin
            if (frameEnd) begin
                validFlag <= '0;
            end
            // later write wins over the clear for this one bin
            if (wrEn) begin
                validFlag[wrIdx] <= 1'b1;
            end
        end
    end

    // count storage does read-modify-write in one cycle
    always_ff @(posedge clk) begin
        if (wrEn) begin
            countMem[wrIdx] <= nextCount;
        end
    end

    // registered result with its pixel and bin tags
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            cntValid <= 1'b0;
            binCount <= '0;
            cntPixel <= '0;
            cntBin   <= '0;
        end else begin
            cntValid <= wrEn;
            if (wrEn) begin
                binCount <= nextCount;
                cntPixel <= pixelIdx;
                cntBin   <= addr;
            end
        end
    end

    // counter overflow would show up as a zero count
    assert property (@(posedge clk) disable iff (!combin_res)
        wrEn |=> binCount != '0);

endmodule

//--- hisPeakTracker.sv
`include "hisBuilder_defines.svh"

module hisPeakTracker (
    input  logic                     clk,
    input  logic                     combin_res,
    input  logic                     cntValid,
    input  logic                     frameEnd,
    input  hisBuilderPkg::binCount_t binCount,
    input  hisBuilderPkg::pixelIdx_t cntPixel,
    input  hisBuilderPkg::binIdx_t   cntBin,
    output logic                     rdValid,
    output hisBuilderPkg::pixelIdx_t rdPixel,
    output hisBuilderPkg::binIdx_t   rdBin
);
    import hisBuilderPkg::*;

    // live peak per pixel
    binCount_t liveMax [`HIS_PIXEL_NUM];
    binIdx_t   liveBin [`HIS_PIXEL_NUM];

    // frozen peak bins for readout
    binIdx_t   snapBin [`HIS_PIXEL_NUM];

    logic      snapReq;
    logic      rdActive;
    pixelIdx_t rdCnt;

    binCount_t curMax;
    logic      newPeak;

    // in the snapshot cycle the live entry counts as already cleared
    assign curMax  = snapReq ? '0 : liveMax[cntPixel];
    // strictly greater, so ties keep the bin reached first
    assign newPeak = cntValid && (binCount > curMax);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < `HIS_PIXEL_NUM; p++) begin
                liveMax[p] <= '0;
                liveBin[p] <= '0;
            end
            snapReq  <= 1'b0;
            rdActive <= 1'b0;
            rdCnt    <= '0;
        end else begin
            // frame end arrives before the last count, wait one cycle
            snapReq <= frameEnd;
            if (snapReq) begin
                for (int p = 0; p < `HIS_PIXEL_NUM; p++) begin
                    liveMax[p] <= '0;
                    liveBin[p] <= '0;
                end
            end
            // update after the clear so a new-frame hit survives
            if (newPeak) begin
                liveMax[cntPixel] <= binCount;
                liveBin[cntPixel] <= cntBin;
            end
            // readout walks pixels in ascending order
            if (snapReq) begin
                rdActive <= 1'b1;
                rdCnt    <= '0;
            end else if (rdActive) begin
                rdCnt <= rdCnt + 1'b1;
                if (rdCnt == pixelIdx_t'(`HIS_PIXEL_NUM - 1)) begin
                    rdActive <= 1'b0;
                end
            end
        end
    end

    // readout bank is written once per frame
    always_ff @(posedge clk) begin
        if (snapReq) begin
            for (int p = 0; p < `HIS_PIXEL_NUM; p++) begin
                snapBin[p] <= liveBin[p];
            end
        end
    end

    assign rdValid = rdActive;
    assign rdPixel = rdCnt;
    assign rdBin   = snapBin[rdCnt];

    // frames must be long enough that readouts never overlap
    assert property (@(posedge clk) disable iff (!combin_res)
        snapReq |-> !rdActive);

endmodule

//--- hisWindowCalc.sv
`include "hisBuilder_defines.svh"

module hisWindowCalc (
    input  logic                     clk,
    input  logic                     combin_res,
    input  logic                     rdValid,
    input  hisBuilderPkg::pixelIdx_t rdPixel,
    input  hisBuilderPkg::binIdx_t   rdBin,
    output logic                     peakValid,
    output hisBuilderPkg::pixelIdx_t peakPixel,
    output hisBuilderPkg::binIdx_t   peakBin,
    output hisBuilderPkg::fineIdx_t  winLow,
    output hisBuilderPkg::fineIdx_t  winHigh
);
    import hisBuilderPkg::*;

    localparam fineIdx_t HALF     = fineIdx_t'(`HIS_HALF_WIN);
    localparam fineIdx_t FULL     = fineIdx_t'(2 * `HIS_HALF_WIN);
    localparam fineIdx_t FINE_MAX = '1;

    fineIdx_t centre;
    fineIdx_t lowNext;
    fineIdx_t highNext;

    // coarse bin scaled up to fine units
    assign centre = fineIdx_t'(rdBin) << (`HIS_NP - `HIS_NB);

    // fixed-width window pushed inside the fine range
    always_comb begin
        if (centre <= HALF) begin
            lowNext  = '0;
            highNext = FULL;
        end else if (centre >= FINE_MAX - HALF) begin
            lowNext  = FINE_MAX - FULL;
            highNext = FINE_MAX;
        end else begin
            lowNext  = centre - HALF;
            highNext = centre + HALF;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= rdValid;
        end
    end

    // result registers load only on a readout cycle
    always_ff @(posedge clk) begin
        if (rdValid) begin
            peakPixel <= rdPixel;
            peakBin   <= rdBin;
            winLow    <= lowNext;
            winHigh   <= highNext;
        end
    end

    assert property (@(posedge clk) disable iff (!combin_res)
        rdValid |=> winLow < winHigh);

endmodule

//--- hisBuilderTop.sv
module hisBuilderTop (
    input  logic                     clk,
    input  logic                     combin_res,
    input  logic                     wrEn,
    input  hisBuilderPkg::binIdx_t   addr,
    output hisBuilderPkg::binCount_t binCount,
    output logic                     cntValid,
    output logic                     frameDone,
    output logic                     frameParity,
    output logic                     peakValid,
    output hisBuilderPkg::pixelIdx_t peakPixel,
    output hisBuilderPkg::binIdx_t   peakBin,
    output hisBuilderPkg::fineIdx_t  winLow,
    output hisBuilderPkg::fineIdx_t  winHigh
);
    import hisBuilderPkg::*;

    // sample side
    pixelIdx_t pixelIdx;
    pixelIdx_t cntPixel;
    binIdx_t   cntBin;

    // readout side
    logic      rdValid;
    pixelIdx_t rdPixel;
    binIdx_t   rdBin;

    // frame end pulse doubles as the frameDone output
    hisFrameSequencer u_seq (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .pixelIdx    (pixelIdx),
        .frameEnd    (frameDone),
        .frameParity (frameParity)
    );

    hisBinMemory u_mem (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .frameEnd   (frameDone),
        .addr       (addr),
        .pixelIdx   (pixelIdx),
        .cntValid   (cntValid),
        .binCount   (binCount),
        .cntPixel   (cntPixel),
        .cntBin     (cntBin)
    );

    hisPeakTracker u_peak (
        .clk        (clk),
        .combin_res (combin_res),
        .cntValid   (cntValid),
        .frameEnd   (frameDone),
        .binCount   (binCount),
        .cntPixel   (cntPixel),
        .cntBin     (cntBin),
        .rdValid    (rdValid),
        .rdPixel    (rdPixel),
        .rdBin      (rdBin)
    );

    // one window per readout cycle
    hisWindowCalc u_win (
        .clk        (clk),
        .combin_res (combin_res),
        .rdValid    (rdValid),
        .rdPixel    (rdPixel),
        .rdBin      (rdBin),
        .peakValid  (peakValid),
        .peakPixel  (peakPixel),
        .peakBin    (peakBin),
        .winLow     (winLow),
        .winHigh    (winHigh)
    );

endmodule

//--- tb_hisBuilder.sv
`include "hisBuilder_defines.svh"

module tb_hisBuilder;
    import hisBuilderPkg::*;

    localparam int PIX       = `HIS_PIXEL_NUM;
    localparam int BINS      = `HIS_BIN_NUM;
    localparam int FRAME_LEN = `HIS_DATA_NUM * `HIS_PIXEL_NUM * `HIS_ACQ_NUM;
    localparam int HALF      = `HIS_HALF_WIN;
    localparam int FINE_MAX  = (1 << `HIS_NP) - 1;
    localparam int NUM_TESTS = 5;

    logic      clk;
    logic      combin_res;
    logic      wrEn;
    binIdx_t   addr;
    binCount_t binCount;
    logic      cntValid;
    logic      frameDone;
    logic      frameParity;
    logic      peakValid;
    pixelIdx_t peakPixel;
    binIdx_t   peakBin;
    fineIdx_t  winLow;
    fineIdx_t  winHigh;

    // reference model state
    int modelCnt [PIX][BINS];
    int modelMax [PIX];
    int modelBin [PIX];
    int snapBin  [PIX];
    int mSamp;
    int mPix;
    int mAcq;
    int sinceFinal;

    // expected values lag the drive by one cycle
    logic pendValid;
    logic pendDone;
    int   pendCount;
    logic chkValid;
    logic chkDone;
    logic chkParity;
    logic chkPeakValid;
    int   chkCount;
    int   chkPixel;
    int   chkBin;
    int   chkLow;
    int   chkHigh;

    int    winPick [PIX];
    int    errs [NUM_TESTS];
    int    curTest;
    string testName [NUM_TESTS] = '{"counts", "frameSwitch", "clear", "peakReadout", "windows"};

    hisBuilderTop u_dut (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .addr        (addr),
        .binCount    (binCount),
        .cntValid    (cntValid),
        .frameDone   (frameDone),
        .frameParity (frameParity),
        .peakValid   (peakValid),
        .peakPixel   (peakPixel),
        .peakBin     (peakBin),
        .winLow      (winLow),
        .winHigh     (winHigh)
    );

    always #50 clk = ~clk;

    task automatic reportMismatch(input string what, input int expV, input int actV);
        $display("[ERROR] %s: %s expected %0d actual %0d", testName[curTest], what, expV, actV);
        errs[curTest]++;
    endtask

    // window bounds straight from the clamping table
    function automatic int windowLow(input int bin);
        int centre;
        centre = bin << (`HIS_NP - `HIS_NB);
        if (centre <= HALF) return 0;
        if (centre >= FINE_MAX - HALF) return FINE_MAX - 2 * HALF;
        return centre - HALF;
    endfunction

    function automatic int windowHigh(input int bin);
        int centre;
        centre = bin << (`HIS_NP - `HIS_NB);
        if (centre <= HALF) return 2 * HALF;
        if (centre >= FINE_MAX - HALF) return FINE_MAX;
        return centre + HALF;
    endfunction

    // bin pattern per test mode
    function automatic int pickBin(input int mode);
        case (mode)
            // ties and late winners
            1: begin
                if (mPix == 0) return (mSamp % 2 == 0) ? 3 : 9;
                if (mPix == 1) return (mSamp % 2 == 0) ? 12 : 2;
                if (mPix == 2) return (mSamp < 3) ? 6 : 10;
                return (mAcq == 0) ? 1 : 14;
            end
            // dominant bin with one stray hit
            2: return (mSamp == 7) ? (winPick[mPix] + 5) % BINS : winPick[mPix];
            default: return $urandom % BINS;
        endcase
    endfunction

    task automatic closeFrame();
        for (int p = 0; p < PIX; p++) begin
            snapBin[p]  = modelBin[p];
            modelMax[p] = 0;
            modelBin[p] = 0;
            for (int b = 0; b < BINS; b++) begin
                modelCnt[p][b] = 0;
            end
        end
        sinceFinal = 0;
        pendDone   = 1'b1;
    endtask

    // one clock cycle that drives after the edge and updates the model
    task automatic step(input logic en, input int bin);
        int pix;
        int cnt;
        @(posedge clk);
        #10;
        chkValid = pendValid;
        chkCount = pendCount;
        chkDone  = pendDone;
        if (pendDone) begin
            chkParity = ~chkParity;
        end
        if (sinceFinal < 1000) begin
            sinceFinal++;
        end
        // readout shows up four cycles after the final sample
        chkPeakValid = (sinceFinal >= 4) && (sinceFinal < 4 + PIX);
        if (chkPeakValid) begin
            chkPixel = sinceFinal - 4;
            chkBin   = snapBin[chkPixel];
            chkLow   = windowLow(chkBin);
            chkHigh  = windowHigh(chkBin);
        end
        wrEn      = en;
        addr      = binIdx_t'(bin);
        pendValid = en;
        pendDone  = 1'b0;
        if (en) begin
            pix = mPix;
            modelCnt[pix][bin]++;
            cnt       = modelCnt[pix][bin];
            pendCount = cnt;
            // strictly greater keeps the first bin on a tie
            if (cnt > modelMax[pix]) begin
                modelMax[pix] = cnt;
                modelBin[pix] = bin;
            end
            if (mSamp == `HIS_DATA_NUM - 1) begin
                mSamp = 0;
                if (mPix == PIX - 1) begin
                    mPix = 0;
                    if (mAcq == `HIS_ACQ_NUM - 1) begin
                        mAcq = 0;
                        closeFrame();
                    end else begin
                        mAcq++;
                    end
                end else begin
                    mPix++;
                end
            end else begin
                mSamp++;
            end
        end
    endtask

    task automatic sendFrame(input int mode, input int maxGap);
        int bin;
        repeat (FRAME_LEN) begin
            bin = pickBin(mode);
            if (maxGap > 0) begin
                repeat ($urandom % (maxGap + 1)) step(1'b0, 0);
            end
            step(1'b1, bin);
        end
    endtask

    // idle until a full peak readout has gone by
    task automatic waitReadout();
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (n < 30 && !(seen && !peakValid)) begin
            step(1'b0, 0);
            if (peakValid) begin
                seen = 1'b1;
            end
            n++;
        end
        if (!(seen && !peakValid)) begin
            $display("%s: timeout, peak readout did not complete", testName[curTest]);
            errs[curTest]++;
        end
    endtask

    task automatic finishTest();
        $display("test %0s done, %0d errors", testName[curTest], errs[curTest]);
    endtask

    // output checks against the model
    assert property (@(posedge clk) disable iff (!combin_res) cntValid == chkValid)
        else reportMismatch("cntValid", chkValid, $sampled(cntValid));
    assert property (@(posedge clk) disable iff (!combin_res) chkValid |-> binCount == chkCount)
        else reportMismatch("binCount", chkCount, $sampled(binCount));
    assert property (@(posedge clk) disable iff (!combin_res) frameDone == chkDone)
        else reportMismatch("frameDone", chkDone, $sampled(frameDone));
    assert property (@(posedge clk) disable iff (!combin_res) frameParity == chkParity)
        else reportMismatch("frameParity", chkParity, $sampled(frameParity));
    assert property (@(posedge clk) disable iff (!combin_res) peakValid == chkPeakValid)
        else reportMismatch("peakValid", chkPeakValid, $sampled(peakValid));
    assert property (@(posedge clk) disable iff (!combin_res) chkPeakValid |-> peakPixel == chkPixel)
        else reportMismatch("peakPixel", chkPixel, $sampled(peakPixel));
    assert property (@(posedge clk) disable iff (!combin_res) chkPeakValid |-> peakBin == chkBin)
        else reportMismatch("peakBin", chkBin, $sampled(peakBin));
    assert property (@(posedge clk) disable iff (!combin_res) chkPeakValid |-> winLow == chkLow)
        else reportMismatch("winLow", chkLow, $sampled(winLow));
    assert property (@(posedge clk) disable iff (!combin_res) chkPeakValid |-> winHigh == chkHigh)
        else reportMismatch("winHigh", chkHigh, $sampled(winHigh));

    initial begin
        #1000000;
        $display("watchdog: simulation did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int total;
        int failed;
        clk          = 1'b0;
        combin_res   = 1'b0;
        wrEn         = 1'b0;
        addr         = '0;
        mSamp        = 0;
        mPix         = 0;
        mAcq         = 0;
        sinceFinal   = 1000;
        pendValid    = 1'b0;
        pendDone     = 1'b0;
        pendCount    = 0;
        chkValid     = 1'b0;
        chkDone      = 1'b0;
        chkParity    = 1'b0;
        chkPeakValid = 1'b0;
        chkCount     = 0;
        curTest      = 0;
        for (int p = 0; p < PIX; p++) begin
            modelMax[p] = 0;
            modelBin[p] = 0;
            snapBin[p]  = 0;
            winPick[p]  = 0;
            for (int b = 0; b < BINS; b++) begin
                modelCnt[p][b] = 0;
            end
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs[t] = 0;
        end
        void'($urandom(4));
        repeat (3) @(posedge clk);
        #10;
        combin_res = 1'b1;

        // random bins with idle gaps
        curTest = 0;
        sendFrame(0, 3);
        waitReadout();
        finishTest();

        // two separate frames toggle the parity twice
        curTest = 1;
        sendFrame(0, 1);
        waitReadout();
        sendFrame(0, 1);
        waitReadout();
        finishTest();

        // back to back frames put the first new sample in the frameDone cycle
        curTest = 2;
        sendFrame(0, 0);
        sendFrame(0, 0);
        waitReadout();
        finishTest();

        curTest = 3;
        sendFrame(1, 0);
        waitReadout();
        finishTest();

        // low clamp, top bin, middle
        curTest = 4;
        winPick = '{0, 15, 7, 1};
        sendFrame(2, 0);
        waitReadout();
        winPick = '{15, 0, 8, 14};
        sendFrame(2, 1);
        waitReadout();
        finishTest();

        repeat (2) step(1'b0, 0);
        total  = 0;
        failed = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += errs[t];
            if (errs[t] != 0) begin
                failed++;
            end
        end
        $display("summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, failed, total);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
hisBuilderPkg.sv
hisFrameSequencer.sv
hisBinMemory.sv
hisPeakTracker.sv
hisWindowCalc.sv
hisBuilderTop.sv
tb_hisBuilder.sv

//--- runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_hisBuilder -o simv

output=$(./obj_dir/simv)
echo "$output"
echo "$output" | grep -q "^NO ERRORS$"
